// File: common/exu_pkg.sv
package exu_pkg;

    localparam int XLEN = 32;

    // alu operation select, pass_b is used for lui
    typedef enum logic [3:0] {
        ALU_ADD    = 4'd0,
        ALU_SUB    = 4'd1,
        ALU_SLL    = 4'd2,
        ALU_SLT    = 4'd3,
        ALU_SLTU   = 4'd4,
        ALU_XOR    = 4'd5,
        ALU_SRL    = 4'd6,
        ALU_SRA    = 4'd7,
        ALU_OR     = 4'd8,
        ALU_AND    = 4'd9,
        ALU_PASS_B = 4'd10
    } alu_op_e;

    // conditional branch compare, none for every non-branch instruction
    typedef enum logic [2:0] {
        BR_NONE = 3'd0,
        BR_EQ   = 3'd1,
        BR_NE   = 3'd2,
        BR_LT   = 3'd3,
        BR_GE   = 3'd4,
        BR_LTU  = 3'd5,
        BR_GEU  = 3'd6
    } br_cond_e;

    // one decoded instruction as handed over by decode
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] imm;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
        logic [XLEN-1:0] rs1_val;     // register file value, may be stale
        logic [XLEN-1:0] rs2_val;
        alu_op_e         alu_op;
        logic            src1_is_pc;
        logic            src2_is_imm;
        br_cond_e        br_cond;
        logic            is_jal;
        logic            is_jalr;
        logic            is_load;
        logic            is_store;
        logic            gpr_we;
    } dec_op_t;

    // record passed on to the load/store stage
    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] result;      // alu value, link address or memory address
        logic [XLEN-1:0] store_data;
        logic [4:0]      rd;
        logic            gpr_we;
        logic            is_load;
        logic            is_store;
    } exe_result_t;

endpackage

// File: logic/alu.sv
module alu
    import exu_pkg::*;
(
    input  alu_op_e         op,
    input  logic [XLEN-1:0] a,
    input  logic [XLEN-1:0] b,
    output logic [XLEN-1:0] y
);

    logic [4:0] shamt;
    logic       lt_s;
    logic       lt_u;

    assign shamt = b[4:0];
    assign lt_s  = $signed(a) < $signed(b);
    assign lt_u  = a < b;

    always_comb begin
        case (op)
            ALU_ADD: begin
                y = a + b;
            end
            ALU_SUB: begin
                y = a - b;
            end
            ALU_SLL: begin
                y = a << shamt;
            end
            ALU_SLT: begin
                y = {{(XLEN-1){1'b0}}, lt_s};
            end
            ALU_SLTU: begin
                y = {{(XLEN-1){1'b0}}, lt_u};
            end
            ALU_XOR: begin
                y = a ^ b;
            end
            ALU_SRL: begin
                y = a >> shamt;
            end
            ALU_SRA: begin
                y = $unsigned($signed(a) >>> shamt);   // keeps the sign bit
            end
            ALU_OR: begin
                y = a | b;
            end
            ALU_AND: begin
                y = a & b;
            end
            ALU_PASS_B: begin
                y = b;   // lui
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

// File: logic/branch_unit.sv
module branch_unit
    import exu_pkg::*;
(
    input  logic [XLEN-1:0] pc,
    input  logic [XLEN-1:0] imm,
    input  logic [XLEN-1:0] src1,
    input  logic [XLEN-1:0] src2,
    input  br_cond_e        br_cond,
    input  logic            is_jal,
    input  logic            is_jalr,
    output logic            taken,
    output logic [XLEN-1:0] target
);

    logic cond_true;
    logic [XLEN-1:0] jalr_sum;

    always_comb begin
        case (br_cond)
            BR_EQ: begin
                cond_true = (src1 == src2);
            end
            BR_NE: begin
                cond_true = (src1 != src2);
            end
            BR_LT: begin
                cond_true = $signed(src1) < $signed(src2);
            end
            BR_GE: begin
                cond_true = $signed(src1) >= $signed(src2);
            end
            BR_LTU: begin
                cond_true = src1 < src2;
            end
            BR_GEU: begin
                cond_true = src1 >= src2;
            end
            default: begin
                cond_true = 1'b0;
            end
        endcase
    end

    assign jalr_sum = src1 + imm;
    assign taken    = is_jal || is_jalr || cond_true;

    // jalr drops bit 0 of the sum as the ISA requires
    assign target = is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;

endmodule

// File: exu/operand_bypass.sv
module operand_bypass
    import exu_pkg::*;
#(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  dec_op_t         in_op,
    input  logic            push,
    input  logic [XLEN-1:0] push_val,
    input  logic            load_data_valid,
    input  logic [XLEN-1:0] load_data,
    output logic [XLEN-1:0] src1,
    output logic [XLEN-1:0] src2,
    output logic            stall
);

    typedef struct packed {
        logic [4:0]      rd;
        logic [XLEN-1:0] val;
        logic            vld;
        logic            pend;   // load issued, data not back yet
    } hist_t;

    typedef struct packed {
        logic [XLEN-1:0] val;
        logic            wait_ld;
    } fwd_t;

    hist_t hist   [BYPASS_DEPTH];   // entry 0 is the newest
    hist_t filled [BYPASS_DEPTH];
    hist_t new_entry;
    fwd_t  fwd1;
    fwd_t  fwd2;

    // scan from oldest to newest so the youngest writer of rs wins
    function automatic fwd_t lookup(input logic [4:0] rs, input logic [XLEN-1:0] rf_val);
        fwd_t f;
        f.val     = rf_val;
        f.wait_ld = 1'b0;
        for (int i = BYPASS_DEPTH - 1; i >= 0; i--) begin
            if (hist[i].vld && (hist[i].rd == rs) && (rs != 5'd0)) begin
                f.val     = hist[i].val;
                f.wait_ld = hist[i].pend;
            end
        end
        return f;
    endfunction

    always_comb begin
        fwd1 = lookup(in_op.rs1, in_op.rs1_val);
        fwd2 = lookup(in_op.rs2, in_op.rs2_val);
    end

    assign src1  = fwd1.val;
    assign src2  = fwd2.val;
    assign stall = fwd1.wait_ld || fwd2.wait_ld;

    // one load is in flight at a time, so the strobe completes every pending entry
    always_comb begin
        for (int i = 0; i < BYPASS_DEPTH; i++) begin
            filled[i] = hist[i];
            if (load_data_valid && hist[i].vld && hist[i].pend) begin
                filled[i].val  = load_data;
                filled[i].pend = 1'b0;
            end
        end
    end

    always_comb begin
        new_entry.rd   = in_op.rd;
        new_entry.val  = push_val;
        new_entry.vld  = 1'b1;
        new_entry.pend = in_op.is_load;   // fresh load is never filled by this cycle's strobe
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                hist[i] <= '0;
            end
        end else if (push && in_op.gpr_we) begin
            hist[0] <= new_entry;
            for (int i = 1; i < BYPASS_DEPTH; i++) begin
                hist[i] <= filled[i-1];
            end
        end else begin
            for (int i = 0; i < BYPASS_DEPTH; i++) begin
                hist[i] <= filled[i];
            end
        end
    end

endmodule

// File: exu/exu_commit.sv
module exu_commit
    import exu_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  dec_op_t         in_op,
    input  logic            accept,
    input  logic            lsu_ready,
    input  logic [XLEN-1:0] alu_y,
    input  logic [XLEN-1:0] src2,
    input  logic            taken,
    input  logic [XLEN-1:0] target,
    input  logic            redirect_ack,
    output logic            push,
    output logic [XLEN-1:0] push_val,
    output logic            out_valid,
    output exe_result_t     out_res,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc
);

    logic            is_jump;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] result;
    logic            keep;
    logic            redirect_d;
    exe_result_t     res_d;

    assign is_jump  = in_op.is_jal || in_op.is_jalr;
    assign pc_plus4 = in_op.pc + XLEN'(4);
    assign result   = is_jump ? pc_plus4 : alu_y;

    // anything accepted behind an unacknowledged redirect is on the wrong path
    assign keep       = accept && !redirect_valid;
    assign redirect_d = keep && taken && (target != pc_plus4);

    assign push     = keep;
    assign push_val = in_op.is_load ? '0 : result;   // load value arrives later

    always_comb begin
        res_d.pc         = in_op.pc;
        res_d.result     = result;
        res_d.store_data = src2;
        res_d.rd         = in_op.rd;
        res_d.gpr_we     = in_op.gpr_we;
        res_d.is_load    = in_op.is_load;
        res_d.is_store   = in_op.is_store;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out_valid      <= 1'b0;
            redirect_valid <= 1'b0;
        end else begin
            if (lsu_ready) begin
                out_valid <= keep;
            end
            if (redirect_valid) begin
                if (redirect_ack) begin
                    redirect_valid <= 1'b0;
                end
            end else if (redirect_d) begin
                redirect_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lsu_ready && keep) begin
            out_res <= res_d;
        end
        if (redirect_d) begin
            redirect_pc <= target;   // held until fetch acknowledges
        end
    end

endmodule

// File: exu/exu_top.sv
module exu_top
    import exu_pkg::*;
#(
    parameter int BYPASS_DEPTH = 4
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            in_valid,
    input  dec_op_t         in_op,
    output logic            in_ready,
    output logic            out_valid,
    output exe_result_t     out_res,
    input  logic            lsu_ready,
    input  logic            load_data_valid,
    input  logic [XLEN-1:0] load_data,
    output logic            redirect_valid,
    output logic [XLEN-1:0] redirect_pc,
    input  logic            redirect_ack
);

    logic [XLEN-1:0] src1;
    logic [XLEN-1:0] src2;
    logic            stall;
    logic [XLEN-1:0] alu_a;
    logic [XLEN-1:0] alu_b;
    logic [XLEN-1:0] alu_y;
    logic            taken;
    logic [XLEN-1:0] target;
    logic            accept;
    logic            push;
    logic [XLEN-1:0] push_val;

    assign in_ready = lsu_ready && !stall;
    assign accept   = in_valid && in_ready;

    assign alu_a = in_op.src1_is_pc  ? in_op.pc  : src1;
    assign alu_b = in_op.src2_is_imm ? in_op.imm : src2;

    operand_bypass #(
        .BYPASS_DEPTH (BYPASS_DEPTH)
    ) u_bypass (
        .clk             (clk),
        .rst             (rst),
        .in_op           (in_op),
        .push            (push),
        .push_val        (push_val),
        .load_data_valid (load_data_valid),
        .load_data       (load_data),
        .src1            (src1),
        .src2            (src2),
        .stall           (stall)
    );

    alu u_alu (
        .op (in_op.alu_op),
        .a  (alu_a),
        .b  (alu_b),
        .y  (alu_y)
    );

    branch_unit u_branch (
        .pc      (in_op.pc),
        .imm     (in_op.imm),
        .src1    (src1),
        .src2    (src2),
        .br_cond (in_op.br_cond),
        .is_jal  (in_op.is_jal),
        .is_jalr (in_op.is_jalr),
        .taken   (taken),
        .target  (target)
    );

    exu_commit u_commit (
        .clk            (clk),
        .rst            (rst),
        .in_op          (in_op),
        .accept         (accept),
        .lsu_ready      (lsu_ready),
        .alu_y          (alu_y),
        .src2           (src2),
        .taken          (taken),
        .target         (target),
        .redirect_ack   (redirect_ack),
        .push           (push),
        .push_val       (push_val),
        .out_valid      (out_valid),
        .out_res        (out_res),
        .redirect_valid (redirect_valid),
        .redirect_pc    (redirect_pc)
    );

endmodule

// File: sim/exu_assert.sv
module exu_assert
    import exu_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input logic        lsu_ready,
    input logic        out_valid,
    input exe_result_t out_res,
    input logic        redirect_valid,
    input logic        redirect_ack
);

    // the load/store stage sees a steady record while it holds off
    hold_on_backpressure: assert property (@(posedge clk) disable iff (rst)
        !lsu_ready |=> $stable(out_res))
        else $error("out_res changed while lsu_ready was low");

    no_valid_in_reset: assert property (@(posedge clk) rst |-> !out_valid)
        else $error("out_valid high during reset");

    redirect_held: assert property (@(posedge clk) disable iff (rst)
        redirect_valid && !redirect_ack |=> redirect_valid)   // only fetch may clear it
        else $error("redirect_valid dropped before redirect_ack");

endmodule

bind exu_top exu_assert u_exu_assert (
    .clk            (clk),
    .rst            (rst),
    .lsu_ready      (lsu_ready),
    .out_valid      (out_valid),
    .out_res        (out_res),
    .redirect_valid (redirect_valid),
    .redirect_ack   (redirect_ack)
);

// File: sim/tb_exu.sv
module tb_exu
    import exu_pkg::*;
();

    localparam int NUM_TESTS   = 5;
    localparam int TEST_CYCLES = 400;

    logic            clk = 1'b0;
    logic            rst;
    logic            in_valid;
    dec_op_t         in_op;
    logic            in_ready;
    logic            out_valid;
    exe_result_t     out_res;
    logic            lsu_ready;
    logic            load_data_valid;
    logic [XLEN-1:0] load_data;
    logic            redirect_valid;
    logic [XLEN-1:0] redirect_pc;
    logic            redirect_ack;
    logic [31:0]     rng = 32'd91948;
    logic [31:0]     regs [32];   // architectural register values as the model sees them
    int              fail_count = 0;

    exu_top #(.BYPASS_DEPTH(4)) DUT (.*);

    always #4 clk = ~clk;

    function automatic logic [31:0] xorshift();
        logic [31:0] x;
        x = rng;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng = x;
        return x;
    endfunction

    function automatic logic lt_signed(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b);   // differing signs decide alone
    endfunction

    function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                              input logic [31:0] b);
        case (op)
            ALU_ADD:  return a + b;
            ALU_SUB:  return a - b;
            ALU_SLL:  return a << b[4:0];
            ALU_SLT:  return {31'd0, lt_signed(a, b)};
            ALU_SLTU: return {31'd0, a < b};
            ALU_XOR:  return a ^ b;
            ALU_SRL:  return a >> b[4:0];
            ALU_SRA:  return (a >> b[4:0]) | (a[31] ? ~(32'hffff_ffff >> b[4:0]) : 32'd0);
            ALU_OR:   return a | b;
            ALU_AND:  return a & b;
            default:  return b;
        endcase
    endfunction

    function automatic logic cond_model(input br_cond_e c, input logic [31:0] a,
                                        input logic [31:0] b);
        case (c)
            BR_EQ:   return a == b;
            BR_NE:   return a != b;
            BR_LT:   return lt_signed(a, b);
            BR_GE:   return !lt_signed(a, b);
            BR_LTU:  return a < b;
            BR_GEU:  return !(a < b);
            default: return 1'b0;
        endcase
    endfunction

    function automatic logic [31:0] model_result(input dec_op_t op);
        logic [31:0] a;
        logic [31:0] b;
        a = op.src1_is_pc ? op.pc : regs[op.rs1];
        b = op.src2_is_imm ? op.imm : regs[op.rs2];
        if (op.is_jal || op.is_jalr) begin
            return op.pc + 32'd4;   // link address
        end
        return alu_model(op.alu_op, a, b);
    endfunction

    function automatic dec_op_t rand_op();
        dec_op_t     op;
        logic [31:0] r;
        r              = xorshift();
        op             = '0;
        op.pc          = xorshift() & 32'hffff_fffc;
        op.imm         = xorshift();
        op.rd          = (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
        op.rs1         = r[9:5];
        op.rs2         = r[14:10];
        op.rs1_val     = regs[op.rs1];
        op.rs2_val     = regs[op.rs2];
        op.alu_op      = alu_op_e'(r[19:16] % 4'd11);
        op.src1_is_pc  = r[20];
        op.src2_is_imm = r[21];
        op.gpr_we      = 1'b1;
        return op;
    endfunction

    task automatic fail_now();
        fail_count++;
        $display("CHECKS FAILED");
        $fatal(1, "stopped at the first failing check");
    endtask

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got == exp) else begin
            $display("[ERROR] time %0t: %s = %h, expected %h", $time, name, got, exp);
            fail_now();
        end
    endtask

    task automatic check_true(input logic cond, input string what);
        assert (cond) else begin
            $display("[ERROR] time %0t: %s", $time, what);
            fail_now();
        end
    endtask

    task automatic drive_op(input dec_op_t op);
        @(posedge clk);
        in_valid <= 1'b1;
        in_op    <= op;
    endtask

    task automatic accept_op();
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        @(posedge clk);   // handshake completes on this edge
        in_valid <= 1'b0;
    endtask

    task automatic check_out(input dec_op_t op, input logic [31:0] exp, input logic [31:0] sd);
        check_true(out_valid, "out_valid low after an accepted instruction");
        check_eq("out_res.pc", out_res.pc, op.pc);
        check_eq("out_res.result", out_res.result, exp);
        check_eq("out_res.store_data", out_res.store_data, sd);
        check_eq("out_res.rd", 32'(out_res.rd), 32'(op.rd));
        check_eq("out_res.gpr_we", 32'(out_res.gpr_we), 32'(op.gpr_we));
        check_eq("out_res.is_load", 32'(out_res.is_load), 32'(op.is_load));
        check_eq("out_res.is_store", 32'(out_res.is_store), 32'(op.is_store));
    endtask

    task automatic commit_model(input dec_op_t op, input logic [31:0] val);
        if (op.gpr_we && !op.is_load && op.rd != 5'd0) begin
            regs[op.rd] = val;
        end
    endtask

    task automatic run_op(input dec_op_t op);
        logic [31:0] exp;
        logic [31:0] sd;
        exp = model_result(op);
        sd  = regs[op.rs2];
        drive_op(op);
        accept_op();
        @(negedge clk);
        check_out(op, exp, sd);
        commit_model(op, exp);
    endtask

    task automatic run_branch(input dec_op_t op, input logic exp_taken);
        logic [31:0] tgt;
        logic [31:0] exp;
        logic        exp_redir;
        tgt       = op.is_jalr ? ((regs[op.rs1] + op.imm) & 32'hffff_fffe) : op.pc + op.imm;
        exp       = model_result(op);
        exp_redir = exp_taken && (tgt != op.pc + 32'd4);
        drive_op(op);
        accept_op();
        @(negedge clk);
        check_true(out_valid, "branch or jump was not passed on");
        check_eq("redirect_valid", 32'(redirect_valid), 32'(exp_redir));
        if (exp_redir) begin
            check_eq("redirect_pc", redirect_pc, tgt);
        end
        if (op.gpr_we) begin
            check_eq("out_res.result", out_res.result, exp);
        end
        commit_model(op, exp);
    endtask

    task automatic ack_redirect();
        @(posedge clk);
        redirect_ack <= 1'b1;
        @(posedge clk);
        redirect_ack <= 1'b0;
        @(negedge clk);
        check_true(!redirect_valid, "redirect_valid still high after redirect_ack");
    endtask

    task automatic test_alu();
        dec_op_t op;
        for (int r = 1; r < 32; r++) begin
            op             = rand_op();
            op.rd          = 5'(r);
            op.alu_op      = ALU_PASS_B;
            op.src2_is_imm = 1'b1;
            run_op(op);   // loads a random value into every register
        end
        for (int k = 0; k < 44; k++) begin
            op             = rand_op();
            op.alu_op      = alu_op_e'(4'(k % 11));
            op.src1_is_pc  = ((k / 11) & 1) != 0;
            op.src2_is_imm = ((k / 11) & 2) != 0;
            op.is_store    = (k % 4) == 3;
            op.gpr_we      = !op.is_store;
            run_op(op);
        end
    endtask

    task automatic test_forward();
        dec_op_t op;
        op             = rand_op();
        op.rd          = 5'd5;
        op.alu_op      = ALU_PASS_B;
        op.src2_is_imm = 1'b1;
        run_op(op);
        op             = rand_op();
        op.rs1         = 5'd5;
        op.rs2         = 5'd5;
        op.rs1_val     = ~regs[5];   // stale register file copies
        op.rs2_val     = regs[5] ^ 32'd1;
        op.src1_is_pc  = 1'b0;
        op.src2_is_imm = 1'b0;
        op.alu_op      = ALU_ADD;
        run_op(op);
        op             = rand_op();
        op.rd          = 5'd0;
        op.alu_op      = ALU_PASS_B;
        op.src2_is_imm = 1'b1;
        run_op(op);
        op             = rand_op();
        op.rs1         = 5'd0;
        op.rs1_val     = 32'd0;
        op.src1_is_pc  = 1'b0;
        op.alu_op      = ALU_OR;
        run_op(op);
    endtask

    task automatic test_load();
        dec_op_t     ld;
        dec_op_t     rdr;
        logic [31:0] val;
        logic [31:0] exp;
        logic [31:0] sd;
        ld             = rand_op();
        ld.rd          = 5'd9;
        ld.alu_op      = ALU_ADD;
        ld.src1_is_pc  = 1'b0;
        ld.src2_is_imm = 1'b1;
        ld.is_load     = 1'b1;
        run_op(ld);   // result is the address
        rdr            = rand_op();
        rdr.rs1        = 5'd9;
        rdr.rs1_val    = regs[9];
        rdr.src1_is_pc = 1'b0;
        rdr.alu_op     = ALU_ADD;
        val            = xorshift();
        drive_op(rdr);
        repeat (3) begin
            @(negedge clk);
            check_true(!in_ready, "in_ready high while the load result is pending");
        end
        @(posedge clk);
        load_data_valid <= 1'b1;
        load_data       <= val;
        @(negedge clk);
        check_true(!in_ready, "in_ready high before the load data edge");
        @(posedge clk);
        load_data_valid <= 1'b0;
        regs[9] = val;
        exp     = model_result(rdr);
        sd      = regs[rdr.rs2];
        accept_op();
        @(negedge clk);
        check_out(rdr, exp, sd);
        commit_model(rdr, exp);
    endtask

    task automatic test_backpressure();
        dec_op_t     op;
        dec_op_t     nxt;
        exe_result_t snap;
        logic [31:0] exp;
        logic [31:0] sd;
        op = rand_op();
        drive_op(op);
        for (int i = 0; i < 4; i++) begin
            exp = model_result(op);
            sd  = regs[op.rs2];
            accept_op();
            lsu_ready <= 1'b0;
            commit_model(op, exp);
            nxt = rand_op();
            if (i < 3) begin
                in_valid <= 1'b1;
                in_op    <= nxt;
            end
            @(negedge clk);
            check_out(op, exp, sd);
            snap = out_res;
            repeat (3) begin
                @(negedge clk);
                check_true(!in_ready, "in_ready high while lsu_ready is low");
                check_true(out_valid, "out_valid dropped while lsu_ready is low");
                check_true(out_res == snap, "out_res changed while lsu_ready is low");
            end
            @(posedge clk);
            lsu_ready <= 1'b1;
            op = nxt;
        end
    endtask

    task automatic test_branch();
        dec_op_t     op;
        logic [31:0] held_pc;
        op         = rand_op();
        op.gpr_we  = 1'b0;
        op.br_cond = BR_EQ;
        op.rs2     = op.rs1;
        op.rs2_val = op.rs1_val;
        op.imm     = 32'h40;
        run_branch(op, 1'b1);
        held_pc = op.pc + 32'h40;
        for (int d = 0; d < 2; d++) begin
            op             = rand_op();
            op.rd          = 5'd7;
            op.alu_op      = ALU_PASS_B;
            op.src2_is_imm = 1'b1;
            op.is_jal      = (d == 1);   // a wrong-path jump must not re-arm the redirect
            drive_op(op);
            accept_op();
            @(negedge clk);
            check_true(!out_valid, "instruction behind a redirect was passed on");
            check_eq("redirect_pc", redirect_pc, held_pc);
        end
        ack_redirect();
        op             = rand_op();
        op.rs1         = 5'd7;
        op.rs1_val     = regs[7];
        op.src1_is_pc  = 1'b0;
        op.alu_op      = ALU_ADD;
        run_op(op);   // a discarded write to x7 would show up here
        for (int c = 1; c < 7; c++) begin
            op         = rand_op();
            op.gpr_we  = 1'b0;
            op.br_cond = br_cond_e'(3'(c));
            run_branch(op, cond_model(op.br_cond, regs[op.rs1], regs[op.rs2]));
            if (redirect_valid) begin
                ack_redirect();
            end
        end
        op         = rand_op();
        op.is_jal  = 1'b1;
        op.imm     = 32'h200;
        run_branch(op, 1'b1);
        ack_redirect();
        op         = rand_op();
        op.is_jalr = 1'b1;
        run_branch(op, 1'b1);
        if (redirect_valid) begin
            ack_redirect();
        end
        op         = rand_op();
        op.gpr_we  = 1'b0;
        op.br_cond = BR_NE;
        op.rs2     = op.rs1;
        op.rs2_val = op.rs1_val;
        run_branch(op, 1'b0);
    endtask

    initial begin
        repeat (8 + NUM_TESTS * TEST_CYCLES) @(posedge clk);
        $display("[ERROR] watchdog expired before the tests finished");
        $display("CHECKS FAILED");
        $fatal(1, "timeout");
    end

    initial begin
        rst             = 1'b1;
        in_valid        = 1'b0;
        in_op           = '0;
        lsu_ready       = 1'b1;
        load_data_valid = 1'b0;
        load_data       = '0;
        redirect_ack    = 1'b0;
        for (int i = 0; i < 32; i++) begin
            regs[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_alu();
        test_forward();
        test_load();
        test_backpressure();
        test_branch();
        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            $display("CHECKS FAILED");
            $fatal(1, "checks reported errors");
        end
    end

endmodule

// File: sim.f
common/exu_pkg.sv
logic/alu.sv
logic/branch_unit.sv
exu/operand_bypass.sv
exu/exu_commit.sv
exu/exu_top.sv
sim/exu_assert.sv
sim/tb_exu.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert -f sim.f --top-module tb_exu -o tb_exu
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/tb_exu > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
if ! grep -q "ALL CHECKS PASSED" "$LOG"; then
    echo "simulation ended without a result"
    exit 1
fi
exit 0
